// ==== axi_mem_sys_testdata.txt ====
// kind addr wdata strb exp_data exp_resp, all hex
// kind 0 data write, 1 data read, 2 fetch, 3 fetch and data read together
0 00000000 11223344 f 00000000 0
1 00000000 00000000 0 11223344 0
0 00000004 aabbccdd f 00000000 0
0 00000004 00005566 3 00000000 0
1 00000004 00000000 0 aabb5566 0
0 00000008 deadbeef f 00000000 0
0 00000008 77000000 8 00000000 0
1 00000008 00000000 0 77adbeef 0
0 0000000c 01020304 f 00000000 0
0 0000000c 00990000 4 00000000 0
2 0000000c 00000000 0 01990304 0
1 0000000c 00000000 0 01990304 0
2 00000000 00000000 0 11223344 0
3 00000004 00000000 0 aabb5566 0
3 00000008 00000000 0 77adbeef 0
0 000003fc cafef00d f 00000000 0
1 000003fc 00000000 0 cafef00d 0
0 00000400 12345678 f 00000000 2
1 00000400 00000000 0 00000000 2
1 00000000 00000000 0 11223344 0
1 000003fc 00000000 0 cafef00d 0
2 00000800 00000000 0 00000000 2
1 00001000 00000000 0 00000000 2
0 00000010 a5a5a5a5 f 00000000 0
0 00000010 00003c00 2 00000000 0
3 00000010 00000000 0 a5a53ca5 0
2 000003fc 00000000 0 cafef00d 0
0 80000010 ffffffff f 00000000 2
1 00000010 00000000 0 a5a53ca5 0

// ==== axi_mem_sys.f ====
+incdir+.
axi_mem_pkg.sv
axi_lite_if.sv
axi_mem_arbiter.sv
axi_sram_slave.sv
axi_mem_sys.sv
tb_axi_mem_sys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the axi_mem_sys testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module tb_axi_mem_sys -f axi_mem_sys.f

# exit status of the run is ignored, the log decides
./obj_dir/Vtb_axi_mem_sys > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
	echo "run_sim: FAIL"
	exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
	echo "run_sim: FAIL (no completion line)"
	exit 1
fi
echo "run_sim: PASS"

// ==== tb_axi_mem_sys.sv ====
`include "axi_mem_settings.svh"

module tb_axi_mem_sys;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_ENT = 64;
	localparam logic [31:0] KIND_WR = 32'd0;
	localparam logic [31:0] KIND_DRD = 32'd1;
	localparam logic [31:0] KIND_IRD = 32'd2;
	localparam logic [31:0] KIND_BOTH = 32'd3; // fetch and load raised together

	logic clk;
	logic rst;
	logic [`AXI_ADDR_W-1:0] inst_ar_addr_i;
	logic inst_ar_valid_i;
	logic inst_ar_ready_o;
	logic inst_r_valid_o;
	logic inst_r_ready_i;
	logic [`AXI_DATA_W-1:0] inst_r_data_o;
	logic [1:0] inst_r_resp_o;
	logic [`AXI_ADDR_W-1:0] data_ar_addr_i;
	logic [`AXI_ADDR_W-1:0] data_aw_addr_i;
	logic data_ar_valid_i;
	logic data_ar_ready_o;
	logic data_r_valid_o;
	logic data_r_ready_i;
	logic [`AXI_DATA_W-1:0] data_r_data_o;
	logic [`AXI_DATA_W-1:0] data_w_data_i;
	logic [1:0] data_r_resp_o;
	logic [1:0] data_b_resp_o;
	logic data_aw_valid_i;
	logic data_aw_ready_o;
	logic data_w_valid_i;
	logic data_w_ready_o;
	logic [`AXI_STRB_W-1:0] data_w_strb_i;
	logic data_b_valid_o;
	logic data_b_ready_i;

	logic [31:0] td [0:6*MAX_ENT-1]; // kind, addr, wdata, strb, exp data, exp resp
	int n_entries;
	int n_done;
	int seed;
	bit loaded;

	axi_mem_sys u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
			$display("Simulation failed");
			$fatal(1, "stopped at the first error");
		end
	endtask

	function automatic string sig_name(input logic [31:0] kind, input string field);
		if (kind == KIND_WR)
			return {"data_b_", field, "_o"};
		else if (kind == KIND_DRD)
			return {"data_r_", field, "_o"};
		return {"inst_r_", field, "_o"};
	endfunction

	function automatic logic resp_valid(input logic [31:0] kind);
		if (kind == KIND_WR)
			return data_b_valid_o;
		return (kind == KIND_DRD) ? data_r_valid_o : inst_r_valid_o;
	endfunction

	// payload that must hold still under back-pressure
	function automatic logic [31:0] resp_payload(input logic [31:0] kind);
		if (kind == KIND_WR)
			return {30'd0, data_b_resp_o};
		return (kind == KIND_DRD) ? data_r_data_o : inst_r_data_o;
	endfunction

	function automatic logic [1:0] resp_code(input logic [31:0] kind);
		if (kind == KIND_WR)
			return data_b_resp_o;
		return (kind == KIND_DRD) ? data_r_resp_o : inst_r_resp_o;
	endfunction

	task automatic set_ready(input logic [31:0] kind, input logic val);
		if (kind == KIND_WR)
			data_b_ready_i <= val;
		else if (kind == KIND_DRD)
			data_r_ready_i <= val;
		else
			inst_r_ready_i <= val;
	endtask

	task automatic drive_req(input logic [31:0] kind, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [3:0] strb);
		if (kind == KIND_WR) begin
			data_aw_addr_i <= addr;
			data_w_data_i <= wdata;
			data_w_strb_i <= strb;
			data_aw_valid_i <= 1'b1; // aw and w together
			data_w_valid_i <= 1'b1;
		end else if (kind == KIND_DRD) begin
			data_ar_addr_i <= addr;
			data_ar_valid_i <= 1'b1;
		end else begin
			inst_ar_addr_i <= addr;
			inst_ar_valid_i <= 1'b1;
		end
	endtask

	// returns just after the edge that carries the address transfer
	task automatic wait_accept(input logic [31:0] kind);
		logic hs;
		hs = 1'b0;
		while (!hs) begin
			@(negedge clk);
			if (kind == KIND_WR)
				hs = data_aw_ready_o & data_w_ready_o;
			else
				hs = (kind == KIND_DRD) ? data_ar_ready_o : inst_ar_ready_o;
			if (kind == KIND_DRD && inst_ar_valid_i)
				check_value("inst_ar_ready_o", 32'(inst_ar_ready_o), 32'd0); // load wins
		end
		@(posedge clk);
		if (kind == KIND_WR) begin
			data_aw_valid_i <= 1'b0;
			data_w_valid_i <= 1'b0;
		end else if (kind == KIND_DRD)
			data_ar_valid_i <= 1'b0;
		else
			inst_ar_valid_i <= 1'b0;
	endtask

	task automatic other_port_quiet(input logic [31:0] kind);
		if (kind == KIND_IRD) begin
			check_value("data_r_valid_o", 32'(data_r_valid_o), 32'd0);
			check_value("data_b_valid_o", 32'(data_b_valid_o), 32'd0);
		end else
			check_value("inst_r_valid_o", 32'(inst_r_valid_o), 32'd0);
	endtask

	task automatic take_resp(input logic [31:0] kind, input logic [31:0] exp_data,
			input logic [1:0] exp_resp, input bit timed);
		int hold;
		int lat;
		logic [31:0] held;
		hold = {$random(seed)} % 6;
		lat = 0;
		if (hold == 0)
			set_ready(kind, 1'b1); // ready already up when valid rises
		@(negedge clk);
		while (!resp_valid(kind)) begin
			other_port_quiet(kind);
			lat++;
			@(negedge clk);
		end
		if (timed)
			check_value("response latency", lat, `MEM_LATENCY);
		held = resp_payload(kind);
		if (hold != 0) begin
			repeat (hold) begin
				@(negedge clk);
				other_port_quiet(kind);
				check_value(sig_name(kind, "valid"), 32'(resp_valid(kind)), 32'd1);
				check_value(sig_name(kind, (kind == KIND_WR) ? "resp" : "data"),
					resp_payload(kind), held);
			end
			@(posedge clk);
			set_ready(kind, 1'b1);
			@(negedge clk);
		end
		other_port_quiet(kind);
		if (kind != KIND_WR)
			check_value(sig_name(kind, "data"), resp_payload(kind), exp_data);
		check_value(sig_name(kind, "resp"), 32'(resp_code(kind)), 32'(exp_resp));
		@(posedge clk); // response transfer
		set_ready(kind, 1'b0);
	endtask

	initial begin
		wait (loaded);
		repeat (16 + n_entries * (4 * `MEM_LATENCY + 40)) @(posedge clk);
		$display("timeout: transactions did not complete");
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic [31:0] kind;
		logic [31:0] addr;
		seed = 83940;
		n_entries = 0;
		n_done = 0;
		loaded = 1'b0;
		rst = 1'b1;
		inst_ar_addr_i = '0;
		inst_ar_valid_i = 1'b0;
		inst_r_ready_i = 1'b0;
		data_ar_addr_i = '0;
		data_ar_valid_i = 1'b0;
		data_r_ready_i = 1'b0;
		data_aw_addr_i = '0;
		data_aw_valid_i = 1'b0;
		data_w_data_i = '0;
		data_w_strb_i = '0;
		data_w_valid_i = 1'b0;
		data_b_ready_i = 1'b0;
		for (int i = 0; i < 6 * MAX_ENT; i++)
			td[i] = '1; // all ones marks the end of the list
		$readmemh("axi_mem_sys_testdata.txt", td);
		while (n_entries < MAX_ENT && td[6*n_entries] != '1)
			n_entries++;
		loaded = 1'b1;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		for (int e = 0; e < n_entries; e++) begin
			repeat ({$random(seed)} % 5 + 1) @(posedge clk);
			kind = td[6*e];
			addr = td[6*e+1];
			if (kind == KIND_BOTH) begin
				drive_req(KIND_DRD, addr, '0, '0);
				drive_req(KIND_IRD, addr, '0, '0);
				wait_accept(KIND_DRD);
				take_resp(KIND_DRD, td[6*e+4], td[6*e+5][1:0], 1'b0);
				wait_accept(KIND_IRD);
				take_resp(KIND_IRD, td[6*e+4], td[6*e+5][1:0], 1'b0);
			end else begin
				drive_req(kind, addr, td[6*e+2], td[6*e+3][3:0]);
				wait_accept(kind);
				take_resp(kind, td[6*e+4], td[6*e+5][1:0], 1'b1);
			end
			n_done++;
		end
		if (n_done == 0) begin
			$display("no transactions were read from the data file");
			$display("Simulation failed");
			$fatal(1, "empty stimulus");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

// ==== axi_mem_sys.sv ====
`include "axi_mem_settings.svh"

module axi_mem_sys (
	input  logic                   clk,
	input  logic                   rst,
	// fetch master
	input  logic [`AXI_ADDR_W-1:0] inst_ar_addr_i,
	input  logic                   inst_ar_valid_i,
	output logic                   inst_ar_ready_o,
	output logic [`AXI_DATA_W-1:0] inst_r_data_o,
	output logic [1:0]             inst_r_resp_o,
	output logic                   inst_r_valid_o,
	input  logic                   inst_r_ready_i,
	// load/store master
	input  logic [`AXI_ADDR_W-1:0] data_ar_addr_i,
	input  logic                   data_ar_valid_i,
	output logic                   data_ar_ready_o,
	output logic [`AXI_DATA_W-1:0] data_r_data_o,
	output logic [1:0]             data_r_resp_o,
	output logic                   data_r_valid_o,
	input  logic                   data_r_ready_i,
	input  logic [`AXI_ADDR_W-1:0] data_aw_addr_i,
	input  logic                   data_aw_valid_i,
	output logic                   data_aw_ready_o,
	input  logic [`AXI_DATA_W-1:0] data_w_data_i,
	input  logic [`AXI_STRB_W-1:0] data_w_strb_i,
	input  logic                   data_w_valid_i,
	output logic                   data_w_ready_o,
	output logic [1:0]             data_b_resp_o,
	output logic                   data_b_valid_o,
	input  logic                   data_b_ready_i
);

	axi_lite_if inst_bus ();
	axi_lite_if data_bus ();
	axi_lite_if mem_bus ();

	assign inst_bus.ar_addr = inst_ar_addr_i;
	assign inst_bus.ar_valid = inst_ar_valid_i;
	assign inst_ar_ready_o = inst_bus.ar_ready;
	assign inst_r_data_o = inst_bus.r_data;
	assign inst_r_resp_o = inst_bus.r_resp;
	assign inst_r_valid_o = inst_bus.r_valid;
	assign inst_bus.r_ready = inst_r_ready_i;
	// fetch side never writes
	assign inst_bus.aw_addr = '0;
	assign inst_bus.aw_valid = 1'b0;
	assign inst_bus.w_data = '0;
	assign inst_bus.w_strb = '0;
	assign inst_bus.w_valid = 1'b0;
	assign inst_bus.b_ready = 1'b0;

	assign data_bus.ar_addr = data_ar_addr_i;
	assign data_bus.ar_valid = data_ar_valid_i;
	assign data_ar_ready_o = data_bus.ar_ready;
	assign data_r_data_o = data_bus.r_data;
	assign data_r_resp_o = data_bus.r_resp;
	assign data_r_valid_o = data_bus.r_valid;
	assign data_bus.r_ready = data_r_ready_i;
	assign data_bus.aw_addr = data_aw_addr_i;
	assign data_bus.aw_valid = data_aw_valid_i;
	assign data_aw_ready_o = data_bus.aw_ready;
	assign data_bus.w_data = data_w_data_i;
	assign data_bus.w_strb = data_w_strb_i;
	assign data_bus.w_valid = data_w_valid_i;
	assign data_w_ready_o = data_bus.w_ready;
	assign data_b_resp_o = data_bus.b_resp;
	assign data_b_valid_o = data_bus.b_valid;
	assign data_bus.b_ready = data_b_ready_i;

	axi_mem_arbiter u_arb (
		.clk    (clk),
		.rst    (rst),
		.inst_s (inst_bus),
		.data_s (data_bus),
		.mem_m  (mem_bus)
	);

	axi_sram_slave u_mem (
		.clk   (clk),
		.rst   (rst),
		.bus_s (mem_bus)
	);

endmodule

// ==== axi_sram_slave.sv ====
`include "axi_mem_settings.svh"

module axi_sram_slave import axi_mem_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	axi_lite_if.subordinate bus_s
);

	localparam int IDX_W = $clog2(`MEM_WORDS);
	localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_WAIT,
		PH_RESP
	} phase_e;

	phase_e phase;
	logic [CNT_W-1:0] cnt;
	logic [`AXI_DATA_W-1:0] mem [`MEM_WORDS];
	logic [`AXI_ADDR_W-1:0] lat_addr;
	logic [`AXI_DATA_W-1:0] lat_data;
	logic [`AXI_STRB_W-1:0] lat_strb;
	logic lat_wr;
	logic [`AXI_DATA_W-1:0] rdata_q;
	axi_resp_e resp_q;
	logic rd_acc;
	logic wr_acc;
	logic resp_acc;
	logic fire;
	logic in_range;
	logic [IDX_W-1:0] word_idx;

	assign bus_s.ar_ready = (phase == PH_IDLE);
	assign bus_s.aw_ready = (phase == PH_IDLE) & bus_s.aw_valid & bus_s.w_valid;
	assign bus_s.w_ready = (phase == PH_IDLE) & bus_s.aw_valid & bus_s.w_valid;

	assign rd_acc = bus_s.ar_valid & bus_s.ar_ready;
	assign wr_acc = !rd_acc & bus_s.aw_ready & bus_s.w_ready;
	assign resp_acc = (bus_s.r_valid & bus_s.r_ready) | (bus_s.b_valid & bus_s.b_ready);
	assign fire = (phase == PH_WAIT) && (cnt == '0); // latency used up, touch the array

	assign word_idx = lat_addr[IDX_W+1:2];
	assign in_range = (lat_addr[`AXI_ADDR_W-1:IDX_W+2] == '0);

	// response stays up until the master takes it
	assign bus_s.r_valid = (phase == PH_RESP) & !lat_wr;
	assign bus_s.r_data = rdata_q;
	assign bus_s.r_resp = resp_q;
	assign bus_s.b_valid = (phase == PH_RESP) & lat_wr;
	assign bus_s.b_resp = resp_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= PH_IDLE;
			cnt <= '0;
		end else begin
			case (phase)
				PH_IDLE: begin
					if (rd_acc || wr_acc) begin
						phase <= PH_WAIT;
						cnt <= CNT_W'(`MEM_LATENCY - 1);
					end
				end
				PH_WAIT: begin
					if (fire)
						phase <= PH_RESP;
					else
						cnt <= cnt - 1'b1;
				end
				PH_RESP: begin
					if (resp_acc)
						phase <= PH_IDLE; // ready again one cycle later
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

	// request latch and response payload
	always_ff @(posedge clk) begin
		if (rd_acc) begin
			lat_addr <= bus_s.ar_addr;
			lat_wr <= 1'b0;
		end else if (wr_acc) begin
			lat_addr <= bus_s.aw_addr;
			lat_data <= bus_s.w_data;
			lat_strb <= bus_s.w_strb;
			lat_wr <= 1'b1;
		end
		if (fire) begin
			rdata_q <= (!lat_wr && in_range) ? mem[word_idx] : '0;
			if (in_range)
				resp_q <= RESP_OKAY;
			else
				resp_q <= RESP_SLVERR;
		end
	end

	// byte merge, out-of-range writes are dropped
	always_ff @(posedge clk) begin
		if (fire && lat_wr && in_range) begin
			for (int b = 0; b < `AXI_STRB_W; b++) begin
				if (lat_strb[b])
					mem[word_idx][8*b +: 8] <= lat_data[8*b +: 8];
			end
		end
	end

	a_r_hold: assert property (@(posedge clk) disable iff (rst)
		bus_s.r_valid && !bus_s.r_ready |=> bus_s.r_valid && $stable(bus_s.r_data));

	a_b_hold: assert property (@(posedge clk) disable iff (rst)
		bus_s.b_valid && !bus_s.b_ready |=> bus_s.b_valid && $stable(bus_s.b_resp));

endmodule

// ==== axi_mem_arbiter.sv ====
module axi_mem_arbiter import axi_mem_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	axi_lite_if.subordinate inst_s,
	axi_lite_if.subordinate data_s,
	axi_lite_if.manager     mem_m
);

	arb_state_e state;
	arb_state_e state_nxt;
	logic idle;
	logic wr_req;
	logic sel_wr;
	logic sel_drd;
	logic sel_inst;
	logic addr_done;
	logic resp_done;

	assign idle = (state == ARB_IDLE);
	assign wr_req = data_s.aw_valid & data_s.w_valid; // aw and w must arrive together

	// fixed priority: data write, data read, fetch
	assign sel_wr = idle & wr_req;
	assign sel_drd = idle & !wr_req & data_s.ar_valid;
	assign sel_inst = idle & !wr_req & !data_s.ar_valid & inst_s.ar_valid;

	// address phase goes straight through, no added cycle
	assign mem_m.ar_addr = sel_inst ? inst_s.ar_addr : data_s.ar_addr;
	assign mem_m.ar_valid = sel_drd | sel_inst;
	assign mem_m.aw_addr = data_s.aw_addr;
	assign mem_m.aw_valid = sel_wr;
	assign mem_m.w_data = data_s.w_data;
	assign mem_m.w_strb = data_s.w_strb;
	assign mem_m.w_valid = sel_wr;

	// only the winner sees ready, losers keep waiting
	assign data_s.ar_ready = sel_drd & mem_m.ar_ready;
	assign data_s.aw_ready = sel_wr & mem_m.aw_ready;
	assign data_s.w_ready = sel_wr & mem_m.w_ready;
	assign inst_s.ar_ready = sel_inst & mem_m.ar_ready;

	// response payload is shared, valid goes to the owner only
	assign data_s.r_data = mem_m.r_data;
	assign data_s.r_resp = mem_m.r_resp;
	assign data_s.r_valid = (state == ARB_BUSY_DATA) & mem_m.r_valid;
	assign data_s.b_resp = mem_m.b_resp;
	assign data_s.b_valid = (state == ARB_BUSY_DATA) & mem_m.b_valid;
	assign inst_s.r_data = mem_m.r_data;
	assign inst_s.r_resp = mem_m.r_resp;
	assign inst_s.r_valid = (state == ARB_BUSY_INST) & mem_m.r_valid;

	assign mem_m.r_ready = (state == ARB_BUSY_DATA) ? data_s.r_ready :
		(state == ARB_BUSY_INST) ? inst_s.r_ready : 1'b0;
	assign mem_m.b_ready = (state == ARB_BUSY_DATA) & data_s.b_ready;

	// fetch port is read-only
	assign inst_s.aw_ready = 1'b0;
	assign inst_s.w_ready = 1'b0;
	assign inst_s.b_valid = 1'b0;
	assign inst_s.b_resp = RESP_OKAY;

	assign addr_done = (mem_m.ar_valid & mem_m.ar_ready) |
		(mem_m.aw_valid & mem_m.aw_ready & mem_m.w_ready);
	assign resp_done = (mem_m.r_valid & mem_m.r_ready) | (mem_m.b_valid & mem_m.b_ready);

	always_comb begin
		state_nxt = state;
		case (state)
			ARB_IDLE: begin
				if (addr_done) begin
					if (sel_inst)
						state_nxt = ARB_BUSY_INST;
					else
						state_nxt = ARB_BUSY_DATA;
				end
			end
			ARB_BUSY_DATA, ARB_BUSY_INST: begin
				if (resp_done) // any response code ends the lock
					state_nxt = ARB_IDLE;
			end
			default: state_nxt = ARB_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= ARB_IDLE;
		else
			state <= state_nxt;
	end

	// fetch master gets a response only after its own address was taken
	a_inst_r_owner: assert property (@(posedge clk) disable iff (rst)
		inst_s.r_valid |-> state == ARB_BUSY_INST &&
			($past(state) == ARB_BUSY_INST || $past(inst_s.ar_valid && inst_s.ar_ready)));

	// an address is only offered while arbiter and memory are both idle
	a_no_addr_busy: assert property (@(posedge clk) disable iff (rst)
		(mem_m.ar_valid || mem_m.aw_valid || mem_m.w_valid) |-> idle && mem_m.ar_ready);

endmodule

// ==== axi_lite_if.sv ====
`include "axi_mem_settings.svh"

interface axi_lite_if import axi_mem_pkg::*; ();

	// read address
	logic [`AXI_ADDR_W-1:0] ar_addr;
	logic ar_valid;
	logic ar_ready;

	// read data
	logic [`AXI_DATA_W-1:0] r_data;
	axi_resp_e r_resp;
	logic r_valid;
	logic r_ready;

	// write address
	logic [`AXI_ADDR_W-1:0] aw_addr;
	logic aw_valid;
	logic aw_ready;

	// write data
	logic [`AXI_DATA_W-1:0] w_data;
	logic [`AXI_STRB_W-1:0] w_strb;
	logic w_valid;
	logic w_ready;

	// write response
	axi_resp_e b_resp;
	logic b_valid;
	logic b_ready;

	modport manager (
		output ar_addr, ar_valid, input ar_ready,
		input r_data, r_resp, r_valid, output r_ready,
		output aw_addr, aw_valid, input aw_ready,
		output w_data, w_strb, w_valid, input w_ready,
		input b_resp, b_valid, output b_ready
	);

	modport subordinate (
		input ar_addr, ar_valid, output ar_ready,
		output r_data, r_resp, r_valid, input r_ready,
		input aw_addr, aw_valid, output aw_ready,
		input w_data, w_strb, w_valid, output w_ready,
		output b_resp, b_valid, input b_ready
	);

endinterface

// ==== axi_mem_pkg.sv ====
package axi_mem_pkg;

	// owner of the shared memory port
	typedef enum logic [1:0] {
		ARB_IDLE      = 2'd0,
		ARB_BUSY_DATA = 2'd1, // load/store master holds the port
		ARB_BUSY_INST = 2'd2  // fetch master holds the port
	} arb_state_e;

	// subset of the AXI response codes
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'd0,
		RESP_SLVERR = 2'd2
	} axi_resp_e;

endpackage

// ==== axi_mem_settings.svh ====
`ifndef AXI_MEM_SETTINGS_SVH
`define AXI_MEM_SETTINGS_SVH

// byte address width of both masters and the shared port
`define AXI_ADDR_W 32

// data bus width, one strobe bit per byte
`define AXI_DATA_W 32
`define AXI_STRB_W (`AXI_DATA_W / 8)

// sram depth in 32-bit words
`define MEM_WORDS 256

// cycles from address accept to response valid
`define MEM_LATENCY 3

`endif
